// ==== design/ddc_defs.svh ====
/*
 * Settings and readback addresses, bus widths and limits for the DDC chain.
 * Included by every module that touches the settings bus or the output word.
 */
`ifndef DDC_DEFS_SVH
`define DDC_DEFS_SVH

// User register space starts at 128
`define SR_FREQ_ADDR      8'd132
`define SR_SCALE_IQ_ADDR  8'd133
`define SR_DECIM_ADDR     8'd134

// Readback addresses
`define RB_COMPAT_NUM     8'd0
`define RB_CIC_MAX_DECIM  8'd2

// Major 1, minor 0
`define COMPAT_NUM        {32'h1, 32'h0}
`define CIC_MAX_DECIM     255
`define RB_BAD_ADDR       64'h0BAD_C0DE_0BAD_C0DE

`define SET_ADDR_W        8
`define SET_DATA_W        32
`define RB_DATA_W         64
`define OUT_DATA_W        32

`endif

// ==== design/ddc_pkg.sv ====
/*
 * Sample, mixer, accumulator and control types shared across the DDC chain,
 * plus the 16-entry cosine table used by the NCO.
 */
package ddc_pkg;

  // Datapath components
  typedef logic signed [15:0] sample_t;
  typedef logic signed [17:0] mixed_t;
  // 18 bits plus 8 bits of growth for decimation up to 255
  typedef logic signed [25:0] acc_t;

  // Control values
  typedef logic [31:0] phase_t;
  typedef logic [7:0]  decim_t;
  typedef logic [3:0]  scale_t;

  // round(32767 * cos(2*pi*k/16))
  // Sine at index k reads entry (k - 4) mod 16
  localparam sample_t COS_TABLE [0:15] = '{
    16'sd32767,
    16'sd30273,
    16'sd23170,
    16'sd12539,
    16'sd0,
    -16'sd12539,
    -16'sd23170,
    -16'sd30273,
    -16'sd32767,
    -16'sd30273,
    -16'sd23170,
    -16'sd12539,
    16'sd0,
    16'sd12539,
    16'sd23170,
    16'sd30273
  };

endpackage

// ==== design/ddc_settings.sv ====
/*
 * User register block for the DDC chain. Decodes the settings strobe bus,
 * issues a restart after frequency or decimation writes, and serves readback.
 */
`timescale 1ns/10ps
`include "ddc_defs.svh"

module ddc_settings (
  input  logic                   i_ce_clk,
  input  logic                   i_arst_n,
  input  logic                   i_set_stb,
  input  logic [`SET_ADDR_W-1:0] i_set_addr,
  input  logic [`SET_DATA_W-1:0] i_set_data,
  input  logic [`SET_ADDR_W-1:0] i_rb_addr,
  output ddc_pkg::phase_t        o_freq,
  output ddc_pkg::decim_t        o_decim,
  output ddc_pkg::scale_t        o_scale,
  output logic                   o_restart,
  output logic [`RB_DATA_W-1:0]  o_rb_data
);
  import ddc_pkg::*;

  logic   wr_freq;
  logic   wr_scale;
  logic   wr_decim;
  decim_t decim_wr;

  assign wr_freq  = i_set_stb && (i_set_addr == `SR_FREQ_ADDR);
  assign wr_scale = i_set_stb && (i_set_addr == `SR_SCALE_IQ_ADDR);
  assign wr_decim = i_set_stb && (i_set_addr == `SR_DECIM_ADDR);
  assign decim_wr = decim_t'(i_set_data[7:0]);

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_freq    <= '0;
      o_decim   <= decim_t'(1);
      o_scale   <= '0;
      o_restart <= 1'b0;
    end else begin
      // Phase and block boundaries are invalid after these change
      o_restart <= wr_freq || wr_decim;
      if (wr_freq)
        o_freq <= i_set_data;
      if (wr_scale)
        o_scale <= scale_t'(i_set_data[3:0]);
      // Zero would never dump, treat it as pass-through
      if (wr_decim)
        o_decim <= (decim_wr == '0) ? decim_t'(1) : decim_wr;
    end
  end

  always_comb begin
    case (i_rb_addr)
      `RB_COMPAT_NUM:    o_rb_data = `COMPAT_NUM;
      `RB_CIC_MAX_DECIM: o_rb_data = 64'(`CIC_MAX_DECIM);
      default:           o_rb_data = `RB_BAD_ADDR;
    endcase
  end

  a_decim_nonzero: assert property (@(posedge i_ce_clk) disable iff (!i_arst_n)
    o_decim != '0)
    else $error("decimation register holds zero");

endmodule

// ==== design/ddc_mixer.sv ====
/*
 * NCO mixer. Rotates each complex input by the accumulated phase using the
 * cosine table, in a two-stage pipeline that stalls as a whole on back-pressure.
 */
`timescale 1ns/10ps

module ddc_mixer (
  input  logic             i_ce_clk,
  input  logic             i_arst_n,
  input  logic             i_restart,
  input  ddc_pkg::phase_t  i_freq,
  input  logic             i_in_valid,
  input  ddc_pkg::sample_t i_in_i,
  input  ddc_pkg::sample_t i_in_q,
  input  logic             i_out_ready,
  output logic             o_in_ready,
  output logic             o_out_valid,
  output ddc_pkg::mixed_t  o_out_i,
  output ddc_pkg::mixed_t  o_out_q
);
  import ddc_pkg::*;

  phase_t             phase;
  logic [3:0]         cos_idx;
  logic [3:0]         sin_idx;
  logic               advance;
  logic               s1_valid;
  sample_t            s1_i;
  sample_t            s1_q;
  sample_t            s1_cos;
  sample_t            s1_sin;
  logic signed [31:0] p_ic;
  logic signed [31:0] p_qs;
  logic signed [31:0] p_is;
  logic signed [31:0] p_qc;
  logic signed [32:0] sum_i;
  logic signed [32:0] sum_q;

  // Whole pipeline moves only when the output slot frees up
  assign advance    = !o_out_valid || i_out_ready;
  assign o_in_ready = advance && !i_restart;

  assign cos_idx = phase[31:28];
  assign sin_idx = cos_idx - 4'd4;

  assign p_ic  = 32'(s1_i) * 32'(s1_cos);
  assign p_qs  = 32'(s1_q) * 32'(s1_sin);
  assign p_is  = 32'(s1_i) * 32'(s1_sin);
  assign p_qc  = 32'(s1_q) * 32'(s1_cos);
  assign sum_i = {p_ic[31], p_ic} - {p_qs[31], p_qs};
  assign sum_q = {p_is[31], p_is} + {p_qc[31], p_qc};

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      phase       <= '0;
      s1_valid    <= 1'b0;
      o_out_valid <= 1'b0;
    end else if (i_restart) begin
      phase       <= '0;
      s1_valid    <= 1'b0;
      o_out_valid <= 1'b0;
    end else if (advance) begin
      if (i_in_valid)
        phase <= phase + i_freq;
      s1_valid    <= i_in_valid;
      o_out_valid <= s1_valid;
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (advance) begin
      s1_i    <= i_in_i;
      s1_q    <= i_in_q;
      s1_cos  <= COS_TABLE[cos_idx];
      s1_sin  <= COS_TABLE[sin_idx];
      // Arithmetic shift by 15, 18 bits kept
      o_out_i <= sum_i[32:15];
      o_out_q <= sum_q[32:15];
    end
  end

  a_out_stable: assert property (@(posedge i_ce_clk) disable iff (!i_arst_n || i_restart)
    (o_out_valid && !i_out_ready) |=> ($stable(o_out_i) && $stable(o_out_q)))
    else $error("mixer output changed while stalled");

endmodule

// ==== design/ddc_decimator.sv ====
/*
 * Integrate-and-dump decimator for one signal component. Sums i_decim inputs,
 * presents the sum once, then starts a fresh block. Used once for I, once for Q.
 */
`timescale 1ns/10ps

module ddc_decimator (
  input  logic            i_ce_clk,
  input  logic            i_arst_n,
  input  logic            i_restart,
  input  ddc_pkg::decim_t i_decim,
  input  logic            i_in_valid,
  input  ddc_pkg::mixed_t i_in_data,
  input  logic            i_out_ready,
  output logic            o_in_ready,
  output logic            o_out_valid,
  output ddc_pkg::acc_t   o_out_data
);
  import ddc_pkg::*;

  decim_t count;
  acc_t   sum;
  acc_t   sum_next;
  logic   accept;
  logic   dump;

  // Input blocked only while a result waits and is not taken this cycle
  assign o_in_ready = !o_out_valid || i_out_ready;
  assign accept     = i_in_valid && o_in_ready;
  assign sum_next   = sum + acc_t'(i_in_data);
  assign dump       = (count + 8'd1) >= i_decim;

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      count       <= '0;
      sum         <= '0;
      o_out_valid <= 1'b0;
    end else if (i_restart) begin
      count       <= '0;
      sum         <= '0;
      o_out_valid <= 1'b0;
    end else begin
      if (o_out_valid && i_out_ready)
        o_out_valid <= 1'b0;
      if (accept) begin
        if (dump) begin
          count       <= '0;
          sum         <= '0;
          o_out_valid <= 1'b1;
        end else begin
          count <= count + 8'd1;
          sum   <= sum_next;
        end
      end
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (accept && dump)
      o_out_data <= sum_next;
  end

  a_count_in_range: assert property (@(posedge i_ce_clk) disable iff (!i_arst_n || i_restart)
    count < i_decim)
    else $error("decimator count beyond block length");

endmodule

// ==== design/ddc_iq_pack.sv ====
/*
 * Joins the I and Q decimator results. Each component is scaled down,
 * clipped to 16 bits and registered into one {I, Q} output word.
 */
`timescale 1ns/10ps
`include "ddc_defs.svh"

module ddc_iq_pack (
  input  logic                   i_ce_clk,
  input  logic                   i_arst_n,
  input  ddc_pkg::scale_t        i_scale,
  input  logic                   i_valid_i,
  input  ddc_pkg::acc_t          i_data_i,
  input  logic                   i_valid_q,
  input  ddc_pkg::acc_t          i_data_q,
  input  logic                   i_out_ready,
  output logic                   o_pair_ready,
  output logic                   o_out_valid,
  output logic [`OUT_DATA_W-1:0] o_out_data
);
  import ddc_pkg::*;

  logic    take;
  sample_t sat_i;
  sample_t sat_q;

  function automatic sample_t scale_sat(input acc_t x, input scale_t sh);
    acc_t shifted;
    shifted = x >>> sh;
    if (shifted > acc_t'(32767))
      return 16'sh7fff;
    else if (shifted < acc_t'(-32768))
      return 16'sh8000;
    else
      return sample_t'(shifted);
  endfunction

  assign o_pair_ready = !o_out_valid || i_out_ready;
  assign take         = i_valid_i && i_valid_q && o_pair_ready;
  assign sat_i        = scale_sat(i_data_i, i_scale);
  assign sat_q        = scale_sat(i_data_q, i_scale);

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n)
      o_out_valid <= 1'b0;
    else if (take)
      o_out_valid <= 1'b1;
    else if (i_out_ready)
      o_out_valid <= 1'b0;
  end

  always_ff @(posedge i_ce_clk) begin
    if (take)
      o_out_data <= {sat_i, sat_q};
  end

  // Both decimators share inputs and ready, so they must dump together
  a_lockstep: assert property (@(posedge i_ce_clk) disable iff (!i_arst_n)
    i_valid_i == i_valid_q)
    else $error("I and Q decimators out of step");

endmodule

// ==== design/ddc_chain.sv ====
/*
 * Single-channel DDC top level: settings block, NCO mixer, one decimator
 * each for I and Q, and the output packer on valid/ready streams.
 */
`timescale 1ns/10ps
`include "ddc_defs.svh"

module ddc_chain (
  input  logic                   i_ce_clk,
  input  logic                   i_arst_n,
  input  logic                   i_set_stb,
  input  logic [`SET_ADDR_W-1:0] i_set_addr,
  input  logic [`SET_DATA_W-1:0] i_set_data,
  input  logic [`SET_ADDR_W-1:0] i_rb_addr,
  output logic [`RB_DATA_W-1:0]  o_rb_data,
  input  logic                   i_in_valid,
  input  ddc_pkg::sample_t       i_in_i,
  input  ddc_pkg::sample_t       i_in_q,
  output logic                   o_in_ready,
  output logic                   o_out_valid,
  output logic [`OUT_DATA_W-1:0] o_out_data,
  input  logic                   i_out_ready
);
  import ddc_pkg::*;

  phase_t freq;
  decim_t decim;
  scale_t scale;
  logic   restart;
  logic   mix_valid;
  logic   mix_ready;
  mixed_t mix_i;
  mixed_t mix_q;
  logic   dec_i_ready;
  logic   dec_q_ready;
  logic   dec_i_valid;
  logic   dec_q_valid;
  acc_t   dec_i_data;
  acc_t   dec_q_data;
  logic   pair_ready;

  //////////////////////////////////////////////////
  // Settings and readback
  //////////////////////////////////////////////////
  ddc_settings u_settings (
    .i_ce_clk(i_ce_clk), .i_arst_n(i_arst_n),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_rb_addr(i_rb_addr),
    .o_freq(freq), .o_decim(decim), .o_scale(scale),
    .o_restart(restart), .o_rb_data(o_rb_data));

  //////////////////////////////////////////////////
  // Mixer
  //////////////////////////////////////////////////
  // Advance only when both decimators can take the sample
  assign mix_ready = dec_i_ready && dec_q_ready;

  ddc_mixer u_mixer (
    .i_ce_clk(i_ce_clk), .i_arst_n(i_arst_n), .i_restart(restart), .i_freq(freq),
    .i_in_valid(i_in_valid), .i_in_i(i_in_i), .i_in_q(i_in_q), .o_in_ready(o_in_ready),
    .o_out_valid(mix_valid), .o_out_i(mix_i), .o_out_q(mix_q), .i_out_ready(mix_ready));

  //////////////////////////////////////////////////
  // Decimators and packer
  //////////////////////////////////////////////////
  ddc_decimator u_dec_i (
    .i_ce_clk(i_ce_clk), .i_arst_n(i_arst_n), .i_restart(restart), .i_decim(decim),
    .i_in_valid(mix_valid), .i_in_data(mix_i), .o_in_ready(dec_i_ready),
    .o_out_valid(dec_i_valid), .o_out_data(dec_i_data), .i_out_ready(pair_ready));

  ddc_decimator u_dec_q (
    .i_ce_clk(i_ce_clk), .i_arst_n(i_arst_n), .i_restart(restart), .i_decim(decim),
    .i_in_valid(mix_valid), .i_in_data(mix_q), .o_in_ready(dec_q_ready),
    .o_out_valid(dec_q_valid), .o_out_data(dec_q_data), .i_out_ready(pair_ready));

  ddc_iq_pack u_pack (
    .i_ce_clk(i_ce_clk), .i_arst_n(i_arst_n), .i_scale(scale),
    .i_valid_i(dec_i_valid), .i_data_i(dec_i_data),
    .i_valid_q(dec_q_valid), .i_data_q(dec_q_data), .o_pair_ready(pair_ready),
    .o_out_valid(o_out_valid), .o_out_data(o_out_data), .i_out_ready(i_out_ready));

endmodule

// ==== tests/ddc_chain_tb.sv ====
/*
 * Directed testbench for the DDC chain. Drives settings and I/Q samples,
 * predicts every output word with a reference model and checks them in order.
 */
`timescale 1ns/10ps
`include "ddc_defs.svh"

module ddc_chain_tb;
  import ddc_pkg::*;

  // About 260 samples plus drains, generous margin for back-pressure
  localparam int MAX_CYCLES = 20000;

  logic                   i_ce_clk;
  logic                   i_arst_n;
  logic                   i_set_stb;
  logic [`SET_ADDR_W-1:0] i_set_addr;
  logic [`SET_DATA_W-1:0] i_set_data;
  logic [`SET_ADDR_W-1:0] i_rb_addr;
  logic [`RB_DATA_W-1:0]  o_rb_data;
  logic                   i_in_valid;
  sample_t                i_in_i;
  sample_t                i_in_q;
  logic                   o_in_ready;
  logic                   o_out_valid;
  logic [`OUT_DATA_W-1:0] o_out_data;
  logic                   i_out_ready;

  integer                 seed;
  int                     cycles;
  logic                   bp_en;
  logic [`OUT_DATA_W-1:0] expected [$];

  // Reference model state
  phase_t m_phase;
  phase_t m_freq;
  decim_t m_decim;
  scale_t m_scale;
  longint m_sum_i;
  longint m_sum_q;
  int     m_count;

  ddc_chain UUT (
    .i_ce_clk(i_ce_clk), .i_arst_n(i_arst_n),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_rb_addr(i_rb_addr), .o_rb_data(o_rb_data),
    .i_in_valid(i_in_valid), .i_in_i(i_in_i), .i_in_q(i_in_q), .o_in_ready(o_in_ready),
    .o_out_valid(o_out_valid), .o_out_data(o_out_data), .i_out_ready(i_out_ready));

  initial begin
    i_ce_clk = 1'b0;
    forever #10 i_ce_clk = ~i_ce_clk;
  end

  always @(posedge i_ce_clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Finished with errors");
      $fatal(1, "Timeout after %0d cycles, the run hung", cycles);
    end
  end

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////
  task automatic check_out(input logic [`OUT_DATA_W-1:0] got,
                           input logic [`OUT_DATA_W-1:0] exp);
    sample_t got_i;
    sample_t got_q;
    sample_t exp_i;
    sample_t exp_q;
    got_i = got[31:16];
    got_q = got[15:0];
    exp_i = exp[31:16];
    exp_q = exp[15:0];
    if (got !== exp) begin
      $display("MISMATCH o_out_data: expected I %h Q %h, got I %h Q %h",
               exp_i, exp_q, got_i, got_q);
      $display("Finished with errors");
      $fatal(1, "Output word check failed");
    end
  endtask

  task automatic check_rb(input logic [`SET_ADDR_W-1:0] addr,
                          input logic [`RB_DATA_W-1:0] got,
                          input logic [`RB_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH o_rb_data at address %h: expected %h got %h", addr, exp, got);
      $display("Finished with errors");
      $fatal(1, "Readback check failed");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: expected %h got %h", name, exp, got);
      $display("Finished with errors");
      $fatal(1, "Flag check failed");
    end
  endtask

  // Every accepted output word must be the next one the model predicted
  always @(negedge i_ce_clk) begin
    #1;
    if (i_arst_n && o_out_valid && i_out_ready) begin
      if (expected.size() == 0) begin
        $display("Output word %h arrived with no word pending", o_out_data);
        $display("Finished with errors");
        $fatal(1, "Extra output word");
      end else begin
        check_out(o_out_data, expected.pop_front());
      end
    end
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  function automatic sample_t clip(input longint sum);
    longint v;
    v = sum >>> m_scale;
    if (v > 64'sd32767)
      return 16'sh7fff;
    else if (v < -64'sd32768)
      return 16'sh8000;
    else
      return sample_t'(v);
  endfunction

  task automatic restart_model();
    m_phase = '0;
    m_sum_i = 0;
    m_sum_q = 0;
    m_count = 0;
  endtask

  task automatic model_sample(input sample_t xi, input sample_t xq);
    logic [3:0] idx;
    longint     c;
    longint     s;
    longint     mi;
    longint     mq;
    idx = m_phase[31:28];
    c = longint'(COS_TABLE[idx]);
    // sin(theta) is cos(theta - pi/2), four table steps back
    s = longint'(COS_TABLE[4'(idx - 4'd4)]);
    mi = (longint'(xi) * c - longint'(xq) * s) >>> 15;
    mq = (longint'(xi) * s + longint'(xq) * c) >>> 15;
    m_phase = m_phase + m_freq;
    m_sum_i += mi;
    m_sum_q += mq;
    m_count++;
    if (m_count == int'(m_decim)) begin
      expected.push_back({clip(m_sum_i), clip(m_sum_q)});
      m_sum_i = 0;
      m_sum_q = 0;
      m_count = 0;
    end
  endtask

  //////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////
  task automatic next_cycle();
    @(negedge i_ce_clk);
    if (bp_en)
      i_out_ready = 1'($random(seed));
    else
      i_out_ready = 1'b1;
  endtask

  task automatic write_reg(input logic [`SET_ADDR_W-1:0] addr,
                           input logic [`SET_DATA_W-1:0] data);
    next_cycle();
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    next_cycle();
    i_set_stb = 1'b0;
    if (addr == `SR_FREQ_ADDR) begin
      m_freq = data;
      restart_model();
    end else if (addr == `SR_DECIM_ADDR) begin
      m_decim = (data[7:0] == 8'd0) ? 8'd1 : data[7:0];
      restart_model();
    end else if (addr == `SR_SCALE_IQ_ADDR) begin
      m_scale = data[3:0];
    end
  endtask

  task automatic send_sample(input sample_t xi, input sample_t xq);
    next_cycle();
    i_in_valid = 1'b1;
    i_in_i     = xi;
    i_in_q     = xq;
    #1;
    while (!o_in_ready) begin
      next_cycle();
      #1;
    end
    model_sample(xi, xq);
  endtask

  task automatic stop_input();
    next_cycle();
    i_in_valid = 1'b0;
  endtask

  task automatic send_random(input int n);
    repeat (n) send_sample(sample_t'($random(seed)), sample_t'($random(seed)));
    stop_input();
  endtask

  task automatic drain();
    while (expected.size() != 0)
      next_cycle();
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////
  task automatic test_readback_reset();
    check_flag("o_out_valid", o_out_valid, 1'b0);
    check_flag("o_in_ready", o_in_ready, 1'b1);
    next_cycle();
    i_rb_addr = `RB_COMPAT_NUM;
    #1;
    check_rb(i_rb_addr, o_rb_data, `COMPAT_NUM);
    next_cycle();
    i_rb_addr = `RB_CIC_MAX_DECIM;
    #1;
    check_rb(i_rb_addr, o_rb_data, 64'(`CIC_MAX_DECIM));
    next_cycle();
    i_rb_addr = 8'd7;
    #1;
    check_rb(i_rb_addr, o_rb_data, `RB_BAD_ADDR);
  endtask

  task automatic test_passthrough();
    send_random(32);
    drain();
  endtask

  task automatic test_decimation();
    write_reg(`SR_DECIM_ADDR, 32'd4);
    send_random(32);
    drain();
    write_reg(`SR_DECIM_ADDR, 32'd7);
    send_random(35);
    drain();
    // Zero maps to one
    write_reg(`SR_DECIM_ADDR, 32'd0);
    send_random(8);
    drain();
  endtask

  task automatic test_frequency();
    write_reg(`SR_FREQ_ADDR, 32'h1000_0000);
    repeat (20) send_sample(16'sd20000, -16'sd5000);
    stop_input();
    drain();
    write_reg(`SR_FREQ_ADDR, 32'h1000_0000);
    send_random(16);
    drain();
  endtask

  task automatic scale_run(input logic [3:0] sh);
    write_reg(`SR_SCALE_IQ_ADDR, {28'h0, sh});
    repeat (8) send_sample(16'sh7fff, 16'sh8000);
    repeat (8) send_sample(16'sh8000, 16'sh7fff);
    stop_input();
    drain();
  endtask

  task automatic test_scaling();
    write_reg(`SR_FREQ_ADDR, 32'h0);
    write_reg(`SR_DECIM_ADDR, 32'd8);
    scale_run(4'd0);
    scale_run(4'd3);
    scale_run(4'd15);
  endtask

  task automatic test_backpressure();
    write_reg(`SR_FREQ_ADDR, 32'h0123_4567);
    write_reg(`SR_DECIM_ADDR, 32'd4);
    write_reg(`SR_SCALE_IQ_ADDR, 32'd2);
    bp_en = 1'b1;
    send_random(64);
    drain();
    bp_en = 1'b0;
  endtask

  initial begin
    seed       = 42323;
    cycles     = 0;
    bp_en      = 1'b0;
    i_arst_n   = 1'b0;
    i_set_stb  = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_rb_addr  = '0;
    i_in_valid = 1'b0;
    i_in_i     = '0;
    i_in_q     = '0;
    i_out_ready = 1'b1;
    m_freq     = '0;
    m_decim    = 8'd1;
    m_scale    = '0;
    restart_model();
    repeat (5) @(posedge i_ce_clk);
    @(negedge i_ce_clk);
    i_arst_n = 1'b1;

    test_readback_reset();
    test_passthrough();
    test_decimation();
    test_frequency();
    test_scaling();
    test_backpressure();
    repeat (10) next_cycle();

    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== ddc_chain.f ====
+incdir+design
design/ddc_pkg.sv
design/ddc_settings.sv
design/ddc_mixer.sv
design/ddc_decimator.sv
design/ddc_iq_pack.sv
design/ddc_chain.sv
tests/ddc_chain_tb.sv

// ==== Makefile ====
# Verilator build and run for the DDC chain
VERILATOR ?= verilator
FILELIST  ?= ddc_chain.f
TB_TOP    ?= ddc_chain_tb
RTL_TOP   ?= ddc_chain
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --timing --assert

SOURCES := $(wildcard design/*.sv design/*.svh tests/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(BUILD_DIR)

run: build
	$(BUILD_DIR)/V$(TB_TOP)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
